//--- sd_probe.f
logic/sd_probe_pkg.sv
logic/spi_master.sv
logic/sd_cmd0_seq.sv
logic/uart_tx.sv
logic/progress_printer.sv
logic/sd_probe.sv
verif/sd_card_model.sv
verif/tb_sd_probe.sv

//--- Makefile
# Verilator build and run for sd_probe

VERILATOR ?= verilator
TOP       ?= tb_sd_probe
FILELIST  ?= sd_probe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_sd_probe.sv
// testbench for sd_probe, runs an answering card and a mute card and checks SPI, UART and LED
`timescale 1ns/1ps

module tb_sd_probe;

    localparam int CLK_DIV    = 2;
    localparam int BAUD_DIV   = 8;
    localparam int POLL_LIMIT = 8;
    localparam int CLK_NS     = 40;
    localparam int BIT_NS     = BAUD_DIV * CLK_NS;
    // worst case bytes per scenario are idle plus command plus full poll
    localparam int BYTE_CYC   = 16 * CLK_DIV + 4;
    localparam int SCEN_CYC   = 16 + (10 + 6 + POLL_LIMIT) * BYTE_CYC +
                                6 * (10 * BAUD_DIV + 4) + 60;
    localparam int WATCHDOG_NS = 2 * 2 * SCEN_CYC * CLK_NS;

    logic       CLOCK_50;
    logic       KEY0;
    logic       SPI_MISO;
    logic       SPI_SCLK;
    logic       SPI_MOSI;
    logic       SPI_SS_n;
    logic       UART_TXD;
    logic       LEDR0;
    logic [7:0] fill_count;
    logic       mute;

    int         seed = 32'hc679d392;
    int         idle_edges;
    int         idle_at_select;
    logic       select_seen;
    logic       select_released;
    logic [7:0] spi_rx_sr;
    int         spi_bits;
    logic [7:0] spi_q [$];
    logic [7:0] uart_q [$];

    sd_probe #(
        .CLK_DIV   (16'(CLK_DIV)),
        .BAUD_DIV  (16'(BAUD_DIV)),
        .POLL_LIMIT(POLL_LIMIT)
    ) sd_probe_i (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .SPI_MISO(SPI_MISO),
        .SPI_SCLK(SPI_SCLK),
        .SPI_MOSI(SPI_MOSI),
        .SPI_SS_n(SPI_SS_n),
        .UART_TXD(UART_TXD),
        .LEDR0   (LEDR0)
    );

    sd_card_model card_i (
        .sclk      (SPI_SCLK),
        .mosi      (SPI_MOSI),
        .cs_n      (SPI_SS_n),
        .fill_count(fill_count),
        .mute      (mute),
        .miso      (SPI_MISO)
    );

    task automatic raise_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            raise_failure($sformatf("FAIL t=%0t %s expected %0h got %0h",
                                    $time, name, expected, actual));
        end
    endtask

    // CMD0 frame as the card expects it
    function automatic logic [7:0] expected_mosi_byte(input int idx);
        case (idx)
            0:       return 8'h40;
            5:       return 8'h95;
            1, 2, 3, 4: return 8'h00;
            default: return 8'hFF;
        endcase
    endfunction

    // ==============================
    // clock, watchdog
    // ==============================
    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #(CLK_NS / 2) CLOCK_50 = ~CLOCK_50;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        raise_failure("watchdog expired before both scenarios finished");
    end

    // ==============================
    // SPI and UART decoders
    // ==============================
    always @(posedge SPI_SCLK) begin
        if (SPI_SS_n) begin
            idle_edges = idle_edges + 1;
            check_value("SPI_MOSI", 1, SPI_MOSI);
        end else begin
            spi_rx_sr = {spi_rx_sr[6:0], SPI_MOSI};
            spi_bits  = spi_bits + 1;
            if (spi_bits == 8) begin
                spi_q.push_back(spi_rx_sr);
                spi_bits = 0;
            end
        end
    end

    always @(negedge SPI_SS_n) begin
        if (KEY0 && !select_seen) begin
            idle_at_select = idle_edges;
            select_seen    = 1'b1;
        end
    end

    always @(posedge SPI_SS_n) begin
        if (select_seen) begin
            select_released = 1'b1;
        end
    end

    // sample near mid bit and clear of clock edges
    initial begin
        logic [7:0] ch;
        forever begin
            @(negedge UART_TXD);
            #(BIT_NS / 2 + 10);
            if (UART_TXD !== 1'b0) begin
                raise_failure("UART start bit did not hold low to mid bit");
            end
            for (int i = 0; i < 8; i++) begin
                #(BIT_NS);
                ch[i] = UART_TXD;
            end
            #(BIT_NS);
            if (UART_TXD !== 1'b1) begin
                raise_failure("UART stop bit missing");
            end
            uart_q.push_back(ch);
        end
    end

    // ==============================
    // interface assertions
    // ==============================
    a_select_sclk_low: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $changed(SPI_SS_n) |-> !SPI_SCLK)
        else raise_failure("SPI_SS_n changed while SPI_SCLK was high");

    a_mosi_stable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(SPI_SCLK) |-> $stable(SPI_MOSI))
        else raise_failure("SPI_MOSI changed at a rising SPI_SCLK edge");

    a_reset_values: assert property (@(posedge CLOCK_50)
        !KEY0 |-> (UART_TXD && SPI_SS_n && !LEDR0))
        else raise_failure("outputs left their reset values while KEY0 was low");

    a_led_holds: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !$fell(LEDR0))
        else raise_failure("LEDR0 dropped without a reset");

    a_led_mute: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        mute |-> !LEDR0)
        else raise_failure("LEDR0 lit although the card never answered");

    // ==============================
    // scenarios
    // ==============================
    task automatic apply_reset(input logic [7:0] fill, input logic mute_card);
        @(posedge CLOCK_50);
        #2;
        KEY0       = 1'b0;
        fill_count = fill;
        mute       = mute_card;
        idle_edges      = 0;
        idle_at_select  = -1;
        select_seen     = 1'b0;
        select_released = 1'b0;
        spi_bits        = 0;
        spi_q.delete();
        uart_q.delete();
        repeat (16) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
    endtask

    task automatic run_scenario(input logic [7:0] fill, input logic mute_card);
        string text;
        int    poll_bytes;
        text       = mute_card ? "SD:--\n" : "SD:01\n";
        poll_bytes = mute_card ? POLL_LIMIT : int'(fill) + 1;
        apply_reset(fill, mute_card);
        // the newline is the last thing the DUT produces
        while (uart_q.size() < 6) begin
            @(negedge CLOCK_50);
        end
        check_value("LEDR0", mute_card ? 0 : 1, LEDR0);
        repeat (40) @(negedge CLOCK_50);
        check_value("idle SPI_SCLK edges", 80, idle_at_select);
        check_value("SPI_SS_n released", 1, select_released);
        check_value("SPI_SS_n low bytes", 6 + poll_bytes, spi_q.size());
        for (int i = 0; i < spi_q.size(); i++) begin
            check_value($sformatf("SPI_MOSI byte %0d", i), expected_mosi_byte(i), spi_q[i]);
        end
        for (int i = 0; i < 6; i++) begin
            check_value($sformatf("UART_TXD char %0d", i), text[i], uart_q[i]);
        end
        check_value("LEDR0", mute_card ? 0 : 1, LEDR0);
    endtask

    initial begin
        logic [7:0] fill;
        KEY0       = 1'b1;
        fill_count = 8'd2;
        mute       = 1'b0;
        #1;
        KEY0 = 1'b0;
        fill = 8'(1 + ($unsigned($random(seed)) % 4));
        // answering card
        run_scenario(fill, 1'b0);
        // mute card lets the poll run to its limit
        run_scenario(8'd2, 1'b1);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- verif/sd_card_model.sv
// behavioral SPI-mode SD card for simulation, answers CMD0 with R1 after fill bytes or stays mute
`timescale 1ns/1ps

module sd_card_model (
    input  logic       sclk,
    input  logic       mosi,
    input  logic       cs_n,
    input  logic [7:0] fill_count,
    input  logic       mute,
    output logic       miso
);

    logic [7:0]  rx_sr     = 8'hFF;
    logic [7:0]  out_sr    = 8'hFF;
    logic [2:0]  bit_cnt   = 3'd0;
    logic [15:0] byte_cnt  = 16'd0;
    logic        last_done = 1'b0;
    // frame opened with the CMD0 index byte
    logic        cmd0_seen = 1'b0;

    // mute card leaves the line pulled high
    assign miso = mute ? 1'b1 : out_sr[7];

    // byte that goes out after byte number done_cnt has been received
    function automatic logic [7:0] response_byte(input logic [15:0] done_cnt,
                                                 input logic [7:0] fill);
        int poll_idx;
        poll_idx = int'(done_cnt) - 6;
        if (done_cnt >= 16'd6 && poll_idx == int'(fill)) begin
            return 8'h01;
        end
        return 8'hFF;
    endfunction

    // ==============================
    // receive side, rising sclk
    // ==============================
    always @(posedge sclk) begin
        if (cs_n) begin
            // idle clocks clear the frame position
            bit_cnt   <= 3'd0;
            byte_cnt  <= 16'd0;
            last_done <= 1'b0;
            cmd0_seen <= 1'b0;
        end else begin
            rx_sr <= {rx_sr[6:0], mosi};
            if (bit_cnt == 3'd7) begin
                bit_cnt   <= 3'd0;
                byte_cnt  <= byte_cnt + 16'd1;
                last_done <= 1'b1;
                // first byte of the frame carries the command index
                if (byte_cnt == 16'd0) begin
                    cmd0_seen <= ({rx_sr[6:0], mosi} == 8'h40);
                end
            end else begin
                bit_cnt   <= bit_cnt + 3'd1;
                last_done <= 1'b0;
            end
        end
    end

    // ==============================
    // transmit side, falling sclk
    // ==============================
    always @(negedge sclk) begin
        if (cs_n) begin
            out_sr <= 8'hFF;
        end else if (last_done) begin
            // next byte on the line before its first rising edge
            out_sr <= cmd0_seen ? response_byte(byte_cnt, fill_count) : 8'hFF;
        end else begin
            out_sr <= {out_sr[6:0], 1'b1};
        end
    end

endmodule

//--- logic/sd_probe.sv
// board top for SD card SPI bring-up: CMD0 sequence, result on UART text and LED
`timescale 1ns/1ps

module sd_probe #(
    // 50 MHz / (2 * 63) is just under 400 kHz for card init
    parameter sd_probe_pkg::div_t CLK_DIV    = 16'd63,
    // 115200 baud at 50 MHz
    parameter sd_probe_pkg::div_t BAUD_DIV   = 16'd434,
    parameter int                 POLL_LIMIT = 8
) (
    input  logic CLOCK_50,
    // push button, low resets
    input  logic KEY0,
    // SD_DAT0
    input  logic SPI_MISO,
    // SD_CLK
    output logic SPI_SCLK,
    // SD_CMD
    output logic SPI_MOSI,
    // SD_DAT3 used as chip select
    output logic SPI_SS_n,
    output logic UART_TXD,
    output logic LEDR0
);

    logic                spi_start;
    logic                spi_busy;
    logic                spi_done;
    sd_probe_pkg::byte_t spi_tx;
    sd_probe_pkg::byte_t spi_rx;
    logic                result_valid;
    logic                result_timeout;
    sd_probe_pkg::byte_t result_r1;
    logic                tx_start;
    logic                tx_busy;
    sd_probe_pkg::byte_t tx_byte;

    // ==============================
    // SD command path
    // ==============================
    sd_cmd0_seq #(
        .POLL_LIMIT(POLL_LIMIT)
    ) sd_cmd0_seq_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .spi_busy      (spi_busy),
        .spi_done      (spi_done),
        .spi_rx        (spi_rx),
        .spi_start     (spi_start),
        .spi_tx        (spi_tx),
        .cs_n          (SPI_SS_n),
        .result_valid  (result_valid),
        .result_r1     (result_r1),
        .result_timeout(result_timeout)
    );

    spi_master #(
        .CLK_DIV(CLK_DIV)
    ) spi_master_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .spi_start(spi_start),
        .spi_tx   (spi_tx),
        .miso     (SPI_MISO),
        .spi_busy (spi_busy),
        .spi_done (spi_done),
        .spi_rx   (spi_rx),
        .sclk     (SPI_SCLK),
        .mosi     (SPI_MOSI)
    );

    // ==============================
    // text report
    // ==============================
    progress_printer progress_printer_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .result_valid  (result_valid),
        .result_r1     (result_r1),
        .result_timeout(result_timeout),
        .tx_busy       (tx_busy),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte)
    );

    uart_tx #(
        .BAUD_DIV(BAUD_DIV)
    ) uart_tx_i (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .tx_start(tx_start),
        .tx_byte (tx_byte),
        .tx_busy (tx_busy),
        .txd     (UART_TXD)
    );

    // led latches a clean idle answer until the next reset
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            LEDR0 <= 1'b0;
        end else if (result_valid && !result_timeout &&
                     result_r1 == sd_probe_pkg::R1_IDLE) begin
            LEDR0 <= 1'b1;
        end
    end

endmodule

//--- logic/progress_printer.sv
// prints "SD:" at reset, then the R1 as two hex digits or "--" and a newline
`timescale 1ns/1ps

module progress_printer (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                result_valid,
    input  sd_probe_pkg::byte_t result_r1,
    input  logic                result_timeout,
    input  logic                tx_busy,
    output logic                tx_start,
    output sd_probe_pkg::byte_t tx_byte
);

    logic [2:0]          char_idx;
    logic                have_result;
    sd_probe_pkg::byte_t r1_q;
    logic                timeout_q;
    sd_probe_pkg::byte_t next_char;
    logic                can_send;

    // upper-case ascii hex digit
    function automatic sd_probe_pkg::byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    // message text by index
    always_comb begin
        case (char_idx)
            3'd0:    next_char = "S";
            3'd1:    next_char = "D";
            3'd2:    next_char = ":";
            3'd3:    next_char = timeout_q ? "-" : hex_char(r1_q[7:4]);
            3'd4:    next_char = timeout_q ? "-" : hex_char(r1_q[3:0]);
            default: next_char = 8'h0A;
        endcase
    end

    // banner goes at once, the rest waits for the result
    assign can_send = !tx_busy && !tx_start &&
                      (char_idx < 3'd3 || (have_result && char_idx < 3'd6));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tx_start    <= 1'b0;
            char_idx    <= '0;
            have_result <= 1'b0;
        end else begin
            tx_start <= can_send;
            if (can_send) begin
                char_idx <= char_idx + 3'd1;
            end
            if (result_valid) begin
                have_result <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (can_send) begin
            tx_byte <= next_char;
        end
        if (result_valid) begin
            r1_q      <= result_r1;
            timeout_q <= result_timeout;
        end
    end

endmodule

//--- logic/uart_tx.sv
// 8N1 serial transmitter, one frame per tx_start, bit time of BAUD_DIV clocks
`timescale 1ns/1ps

module uart_tx #(
    parameter sd_probe_pkg::div_t BAUD_DIV = 16'd434
) (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                tx_start,
    input  sd_probe_pkg::byte_t tx_byte,
    output logic                tx_busy,
    output logic                txd
);

    sd_probe_pkg::div_t baud_cnt;
    logic [3:0]         bit_cnt;
    // stop bit, data lsb first, start bit at the bottom
    logic [9:0]         frame;

    assign txd = frame[0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            frame    <= '1;
        end else if (tx_start && !tx_busy) begin
            tx_busy  <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            frame    <= {1'b1, tx_byte, 1'b0};
        end else if (tx_busy) begin
            if (baud_cnt == BAUD_DIV - 16'd1) begin
                baud_cnt <= '0;
                bit_cnt  <= bit_cnt + 4'd1;
                // line returns to mark as ones shift in
                frame    <= {1'b1, frame[9:1]};
                // end of stop bit
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;
                end
            end else begin
                baud_cnt <= baud_cnt + 16'd1;
            end
        end
    end

    a_no_start_when_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        tx_start |-> !tx_busy)
        else $error("tx_start while tx_busy");

endmodule

//--- logic/sd_cmd0_seq.sv
// SD CMD0 sequencer: 80 idle clocks, CMD0 frame, R1 poll, then one result pulse
`timescale 1ns/1ps

module sd_cmd0_seq #(
    parameter int POLL_LIMIT = 8
) (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                spi_busy,
    input  logic                spi_done,
    input  sd_probe_pkg::byte_t spi_rx,
    output logic                spi_start,
    output sd_probe_pkg::byte_t spi_tx,
    output logic                cs_n,
    output logic                result_valid,
    output sd_probe_pkg::byte_t result_r1,
    output logic                result_timeout
);

    sd_probe_pkg::seq_state_t state;
    logic [15:0]              byte_cnt;
    logic                     xfer_act;
    logic                     r1_hit;

    // R1 starts with a 0 bit, anything with msb set is still fill
    assign r1_hit = !spi_rx[7];

    // command bytes only in the send phase, fill everywhere else
    always_comb begin
        if (state == sd_probe_pkg::ST_SEND_CMD) begin
            spi_tx = sd_probe_pkg::CMD0_BYTES[byte_cnt[2:0]];
        end else begin
            spi_tx = sd_probe_pkg::FILL_BYTE;
        end
    end

    // ==============================
    // byte-by-byte state machine
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state        <= sd_probe_pkg::ST_IDLE_CLOCKS;
            byte_cnt     <= '0;
            xfer_act     <= 1'b0;
            spi_start    <= 1'b0;
            cs_n         <= 1'b1;
            result_valid <= 1'b0;
        end else begin
            spi_start    <= 1'b0;
            result_valid <= 1'b0;
            // launch the next byte once the engine is free
            if (!xfer_act && !spi_busy && state != sd_probe_pkg::ST_DONE) begin
                spi_start <= 1'b1;
                xfer_act  <= 1'b1;
            end
            if (spi_done) begin
                xfer_act <= 1'b0;
                byte_cnt <= byte_cnt + 16'd1;
                case (state)
                    sd_probe_pkg::ST_IDLE_CLOCKS: begin
                        if (byte_cnt == 16'(sd_probe_pkg::IDLE_BYTES - 1)) begin
                            byte_cnt <= '0;
                            cs_n     <= 1'b0;
                            state    <= sd_probe_pkg::ST_SEND_CMD;
                        end
                    end
                    sd_probe_pkg::ST_SEND_CMD: begin
                        if (byte_cnt == 16'd5) begin
                            byte_cnt <= '0;
                            state    <= sd_probe_pkg::ST_POLL;
                        end
                    end
                    sd_probe_pkg::ST_POLL: begin
                        // release the card on an answer or on the limit
                        if (r1_hit || byte_cnt == 16'(POLL_LIMIT - 1)) begin
                            cs_n         <= 1'b1;
                            result_valid <= 1'b1;
                            state        <= sd_probe_pkg::ST_DONE;
                        end
                    end
                    default: begin
                        byte_cnt <= byte_cnt;
                    end
                endcase
            end
        end
    end

    // result payload, only meaningful on result_valid
    always_ff @(posedge CLOCK_50) begin
        if (spi_done && state == sd_probe_pkg::ST_POLL) begin
            result_r1      <= r1_hit ? spi_rx : sd_probe_pkg::FILL_BYTE;
            result_timeout <= !r1_hit;
        end
    end

    // chip select only asserted during command and poll
    a_cs_high_outside: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (state == sd_probe_pkg::ST_IDLE_CLOCKS || state == sd_probe_pkg::ST_DONE) |-> cs_n)
        else $error("cs_n low in idle or done phase");

    // every done from the engine answers a byte this block launched
    a_done_expected: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        spi_done |-> xfer_act)
        else $error("spi_done without a pending transfer");

endmodule

//--- logic/spi_master.sv
// SPI mode 0 byte exchanger, one byte per spi_start, SCLK = clock / (2 * CLK_DIV)
`timescale 1ns/1ps

module spi_master #(
    parameter sd_probe_pkg::div_t CLK_DIV = 16'd63
) (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                spi_start,
    input  sd_probe_pkg::byte_t spi_tx,
    input  logic                miso,
    output logic                spi_busy,
    output logic                spi_done,
    output sd_probe_pkg::byte_t spi_rx,
    output logic                sclk,
    output logic                mosi
);

    sd_probe_pkg::div_t  div_cnt;
    logic [3:0]          edge_cnt;
    sd_probe_pkg::byte_t tx_sr;
    sd_probe_pkg::byte_t rx_sr;
    logic                tick;

    // one sclk half period elapsed
    assign tick = spi_busy && (div_cnt == CLK_DIV - 16'd1);

    // msb first, first bit is on the line a full half period before the rising edge
    assign mosi   = tx_sr[7];
    assign spi_rx = rx_sr;

    // ==============================
    // divider and transmit shifter
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            spi_busy <= 1'b0;
            spi_done <= 1'b0;
            sclk     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            tx_sr    <= sd_probe_pkg::FILL_BYTE;
        end else begin
            spi_done <= 1'b0;
            if (spi_start && !spi_busy) begin
                spi_busy <= 1'b1;
                div_cnt  <= '0;
                edge_cnt <= '0;
                tx_sr    <= spi_tx;
            end else if (tick) begin
                div_cnt  <= '0;
                sclk     <= ~sclk;
                edge_cnt <= edge_cnt + 4'd1;
                // falling edge, next bit out, ones shifted in keep mosi high
                if (sclk) begin
                    tx_sr <= {tx_sr[6:0], 1'b1};
                end
                // 16th edge is the last falling one
                if (edge_cnt == 4'd15) begin
                    spi_busy <= 1'b0;
                    spi_done <= 1'b1;
                end
            end else if (spi_busy) begin
                div_cnt <= div_cnt + 16'd1;
            end
        end
    end

    // miso sampled on the rising edge
    always_ff @(posedge CLOCK_50) begin
        if (tick && !sclk) begin
            rx_sr <= {rx_sr[6:0], miso};
        end
    end

    // the sequencer must wait for the previous byte to finish
    a_no_start_when_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        spi_start |-> !spi_busy)
        else $error("spi_start while spi_busy");

endmodule

//--- logic/sd_probe_pkg.sv
// shared types and SD SPI-mode constants, referenced by scoped name from the RTL
package sd_probe_pkg;

    // ==============================
    // types
    // ==============================
    // one data byte on SPI or UART
    typedef logic [7:0] byte_t;
    // clock divider count
    typedef logic [15:0] div_t;

    // sequencer phases, in the order they run
    typedef enum logic [1:0] {
        ST_IDLE_CLOCKS,
        ST_SEND_CMD,
        ST_POLL,
        ST_DONE
    } seq_state_t;

    // ==============================
    // SD command constants
    // ==============================
    // GO_IDLE_STATE frame, index 0 goes out first
    // 0x95 is the fixed crc7 + end bit for CMD0 with zero argument
    localparam byte_t CMD0_BYTES [0:5] = '{8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95};
    // mosi held high while idling and polling
    localparam byte_t FILL_BYTE = 8'hFF;
    // 10 bytes x 8 bits = 80 sclk cycles, card needs at least 74
    localparam int IDLE_BYTES = 10;
    // in idle state, no error bits
    localparam byte_t R1_IDLE = 8'h01;

endpackage
